/* Makefile */
TOP := boardTop_tb

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o simv

run: compile
	./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* build.f */
hw/boardPkg.sv
hw/uartPkg.sv
hw/resetOnStart.sv
hw/tickGen.sv
hw/uartTx.sv
hw/uartRx.sv
hw/keypadEntry.sv
hw/hexDisplay.sv
hw/boardTop.sv
tb/boardTop_checker.sv
tb/boardTop_tb.sv

/* hw/boardPkg.sv */
package boardPkg;

    // **************************************************
    // Board I/O widths
    // **************************************************
    localparam int numDigits = 8;                    // Seven-segment digits on the board

    typedef logic [20:0]              pbVec;         // Push buttons, key n is bit n
    typedef logic [7:0]               segVec;        // dp gfedcba, active high
    typedef logic [7:0]               ledVec;        // One LED bar
    typedef logic [3:0]               hexDigit;      // One key value
    typedef logic [4*numDigits-1:0]   digitReg;      // Digit n sits in nibble n

    // Key assignments
    localparam int keyClear  = 16;                   // Clears the display register
    localparam int resetKeyA = 0;                    // Reset combination 0 + 3 + 16
    localparam int resetKeyB = 3;
    localparam int resetKeyC = 16;

    // Hex value to gfedcba glyph, lower-case b and d
    function automatic segVec hexToSeg(hexDigit d);
        segVec seg;
        case (d)
            4'h0: seg = 8'h3F;
            4'h1: seg = 8'h06;
            4'h2: seg = 8'h5B;
            4'h3: seg = 8'h4F;
            4'h4: seg = 8'h66;
            4'h5: seg = 8'h6D;
            4'h6: seg = 8'h7D;
            4'h7: seg = 8'h07;
            4'h8: seg = 8'h7F;
            4'h9: seg = 8'h6F;
            4'hA: seg = 8'h77;
            4'hB: seg = 8'h7C;                       // b
            4'hC: seg = 8'h39;
            4'hD: seg = 8'h5E;                       // d
            4'hE: seg = 8'h79;
            4'hF: seg = 8'h71;
        endcase
        return seg;                                  // Decimal point stays dark
    endfunction

    // Pick digit n out of the display register
    function automatic hexDigit digitAt(digitReg r, int n);
        return r[n*4 +: 4];
    endfunction

endpackage

/* hw/boardTop.sv */
`timescale 1ns/1ps

module boardTop #(
    parameter int TICK_DIV     = 120_000,            // 100 Hz tick at 12 MHz
    parameter int CLKS_PER_BIT = 104,                // About 115200 baud at 12 MHz
    parameter int RESET_CYCLES = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  boardPkg::pbVec  pb,
    input  logic            Rx,
    output logic            Tx,
    output boardPkg::segVec ss7,
    output boardPkg::segVec ss6,
    output boardPkg::segVec ss5,
    output boardPkg::segVec ss4,
    output boardPkg::segVec ss3,
    output boardPkg::segVec ss2,
    output boardPkg::segVec ss1,
    output boardPkg::segVec ss0,
    output boardPkg::ledVec left,
    output boardPkg::ledVec right,
    output logic            red,
    output logic            green,
    output logic            blue
);
    import boardPkg::*;
    import uartPkg::*;

    logic    manual;
    logic    sysReset;
    logic    tick;
    uartByte txByte;
    logic    txStart;
    logic    txBusy;
    uartByte rxByte;
    logic    rxValid;
    logic    rxError;
    digitReg digits;

    assign manual = pb[resetKeyA] && pb[resetKeyB] && pb[resetKeyC];  // Button reset

    resetOnStart #(.RESET_CYCLES(RESET_CYCLES)) i_resetOnStart (
        .clk(clk), .reset(reset), .manual(manual), .sysReset(sysReset)
    );

    tickGen #(.TICK_DIV(TICK_DIV)) i_tickGen (.clk(clk), .reset(sysReset), .tick(tick));

    uartTx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uartTx (
        .clk(clk), .reset(sysReset), .txData(txByte), .txStart(txStart),
        .Tx(Tx), .txBusy(txBusy)
    );

    uartRx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uartRx (
        .clk(clk), .reset(sysReset), .Rx(Rx),
        .rxData(rxByte), .rxValid(rxValid), .rxError(rxError)
    );

    keypadEntry i_keypadEntry (
        .clk(clk), .reset(sysReset), .tick(tick), .pb(pb), .digits(digits),
        .txData(txByte), .txStart(txStart), .left(left)
    );

    hexDisplay i_hexDisplay (
        .digits(digits), .ss7(ss7), .ss6(ss6), .ss5(ss5), .ss4(ss4),
        .ss3(ss3), .ss2(ss2), .ss1(ss1), .ss0(ss0)
    );

    // Receive register and sticky status LEDs
    always_ff @(posedge clk or posedge sysReset) begin
        if (sysReset) begin
            right <= '0;
            green <= 1'b0;
            blue  <= 1'b0;
        end else begin
            if (rxValid) begin
                right <= rxByte;                     // Last good byte
                green <= 1'b1;
            end
            if (rxError) blue <= 1'b1;               // Framing error seen
        end
    end

    assign red = txBusy;                             // Lit while a frame goes out

endmodule

/* hw/hexDisplay.sv */
`timescale 1ns/1ps

module hexDisplay (
    input  boardPkg::digitReg digits,
    output boardPkg::segVec   ss7,
    output boardPkg::segVec   ss6,
    output boardPkg::segVec   ss5,
    output boardPkg::segVec   ss4,
    output boardPkg::segVec   ss3,
    output boardPkg::segVec   ss2,
    output boardPkg::segVec   ss1,
    output boardPkg::segVec   ss0
);
    import boardPkg::*;

    // One decoder per digit, ss0 is the rightmost
    assign ss0 = hexToSeg(digitAt(digits, 0));
    assign ss1 = hexToSeg(digitAt(digits, 1));
    assign ss2 = hexToSeg(digitAt(digits, 2));
    assign ss3 = hexToSeg(digitAt(digits, 3));
    assign ss4 = hexToSeg(digitAt(digits, 4));
    assign ss5 = hexToSeg(digitAt(digits, 5));
    assign ss6 = hexToSeg(digitAt(digits, 6));
    assign ss7 = hexToSeg(digitAt(digits, 7));       // Oldest digit on the left

endmodule

/* hw/keypadEntry.sv */
`timescale 1ns/1ps

module keypadEntry (
    input  logic              clk,
    input  logic              reset,
    input  logic              tick,
    input  boardPkg::pbVec    pb,
    output boardPkg::digitReg digits,
    output uartPkg::uartByte  txData,
    output logic              txStart,
    output boardPkg::ledVec   left
);
    import boardPkg::*;
    import uartPkg::*;

    localparam int DW = $bits(digitReg);

    pbVec    prevPb;                                 // Key sample from the previous tick
    pbVec    newPress;
    logic    hexHit;
    logic    clearHit;
    hexDigit keyDigit;
    uartByte lastByte;                               // Last character sent

    // Hex value to its ASCII character
    function automatic uartByte toAscii(hexDigit d);
        uartByte code;
        if (d < 4'd10) code = 8'h30 + uartByte'(d);            // '0' to '9'
        else           code = 8'h41 + uartByte'(d) - 8'd10;    // 'A' to 'F'
        return code;
    endfunction

    // **************************************************
    // Press detection
    // **************************************************
    assign newPress = pb & ~prevPb;                  // Low last tick, high now
    assign hexHit   = |newPress[15:0];
    assign clearHit = newPress[keyClear] &&
                      ((pb & ~(pbVec'(1) << keyClear)) == '0);  // Clear key held alone

    // Lowest index wins
    always_comb begin
        keyDigit = '0;
        for (int i = 15; i >= 0; i--) begin
            if (newPress[i]) keyDigit = hexDigit'(i);
        end
    end

    // **************************************************
    // Display register and transmit strobe
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prevPb   <= '0;
            digits   <= '0;
            lastByte <= '0;
            txStart  <= 1'b0;
        end else begin
            txStart <= 1'b0;
            if (tick) begin
                prevPb <= pb;
                if (hexHit) begin
                    digits   <= {digits[DW-5:0], keyDigit};  // New digit on the right
                    lastByte <= toAscii(keyDigit);
                    txStart  <= 1'b1;
                end else if (clearHit) begin
                    digits <= '0;                    // Left bar keeps the last byte
                end
            end
        end
    end

    assign txData = lastByte;
    assign left   = lastByte;                        // Mirror of the sent character

endmodule

/* hw/resetOnStart.sv */
`timescale 1ns/1ps

module resetOnStart #(
    parameter int RESET_CYCLES = 4
) (
    input  logic clk,
    input  logic reset,                              // External reset pin
    input  logic manual,                             // Button combination
    output logic sysReset
);

    localparam int CW = $clog2(RESET_CYCLES + 1);

    logic [CW-1:0] count;                            // Clocks of reset still to go

    // Either source loads the counter at once, release waits for it to drain
    always_ff @(posedge clk or posedge reset or posedge manual) begin
        if (reset || manual) begin
            count    <= CW'(RESET_CYCLES);
            sysReset <= 1'b1;
        end else begin
            if (count != '0) begin
                count <= count - 1'b1;
            end
            sysReset <= (count > CW'(1));            // Drops on the last count, clean edge
        end
    end

endmodule

/* hw/tickGen.sv */
`timescale 1ns/1ps

module tickGen #(
    parameter int TICK_DIV = 120_000
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int CW = $clog2(TICK_DIV + 1);

    logic [CW-1:0] count;

    // Wrap-around divider, replaces the slow board clock
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (count == CW'(TICK_DIV - 1)) begin
            count <= '0;                             // Period complete
        end else begin
            count <= count + 1'b1;
        end
    end

    assign tick = (count == CW'(TICK_DIV - 1));      // One clock per period

endmodule

/* hw/uartPkg.sv */
package uartPkg;

    // One serial data byte, sent LSB first
    typedef logic [7:0] uartByte;

    // Transmitter phases
    typedef enum logic [1:0] {
        txIdle,                                      // Line high, waiting for start strobe
        txStartBit,                                  // Driving the low start bit
        txData,                                      // Eight data bits
        txStopBit                                    // High stop bit
    } txState;

    // Receiver phases
    typedef enum logic [1:0] {
        rxIdle,                                      // Watching for a falling edge
        rxStartBit,                                  // Confirming start bit at mid-bit
        rxData,                                      // Sampling eight data bits
        rxStopBit                                    // Checking the stop bit
    } rxState;

endpackage

/* hw/uartRx.sv */
`timescale 1ns/1ps

module uartRx #(
    parameter int CLKS_PER_BIT = 104
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             Rx,
    output uartPkg::uartByte rxData,
    output logic             rxValid,
    output logic             rxError
);
    import uartPkg::*;

    localparam int            TW   = $clog2(CLKS_PER_BIT + 1);
    localparam logic [TW-1:0] LAST = TW'(CLKS_PER_BIT - 1);
    localparam logic [TW-1:0] MID  = TW'((CLKS_PER_BIT - 1) / 2);

    rxState        state;
    logic [TW-1:0] timer;
    logic [2:0]    bitIdx;
    uartByte       shiftReg;                         // Fills from the top, LSB first
    logic          rxMeta;
    logic          rxSync;
    logic          rxPrev;
    logic          fallEdge;
    logic          midStart;
    logic          bitDone;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= Rx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    assign fallEdge = rxPrev && !rxSync;
    assign midStart = (timer == MID);                // Half a bit into the start bit
    assign bitDone  = (timer == LAST);               // One full bit from the last sample

    // **************************************************
    // Mid-bit sampler
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= rxIdle;
            timer   <= '0;
            bitIdx  <= '0;
            rxValid <= 1'b0;
            rxError <= 1'b0;
        end else begin
            rxValid <= 1'b0;                         // Pulses last one clock
            rxError <= 1'b0;
            timer   <= timer + 1'b1;
            case (state)
                rxIdle: begin
                    timer <= '0;
                    if (fallEdge) state <= rxStartBit;
                end
                rxStartBit: begin
                    if (midStart) begin
                        timer  <= '0;
                        bitIdx <= '0;
                        state  <= rxSync ? rxIdle : uartPkg::rxData;  // High here is a glitch
                    end
                end
                uartPkg::rxData: begin
                    if (bitDone) begin
                        timer <= '0;
                        if (bitIdx == 3'd7) state <= rxStopBit;
                        else bitIdx <= bitIdx + 1'b1;
                    end
                end
                rxStopBit: begin
                    if (bitDone) begin
                        state   <= rxIdle;
                        rxValid <= rxSync;
                        rxError <= !rxSync;          // Low stop bit is a framing error
                    end
                end
                default: state <= rxIdle;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (state == uartPkg::rxData && bitDone) shiftReg <= {rxSync, shiftReg[7:1]};
        if (state == rxStopBit && bitDone && rxSync) rxData <= shiftReg;  // Good frames only
    end

endmodule

/* hw/uartTx.sv */
`timescale 1ns/1ps

module uartTx #(
    parameter int CLKS_PER_BIT = 104
) (
    input  logic             clk,
    input  logic             reset,
    input  uartPkg::uartByte txData,
    input  logic             txStart,
    output logic             Tx,
    output logic             txBusy
);
    import uartPkg::*;

    localparam int            TW   = $clog2(CLKS_PER_BIT + 1);
    localparam logic [TW-1:0] LAST = TW'(CLKS_PER_BIT - 1);

    txState        state;
    logic [TW-1:0] timer;                            // Clocks into the current bit
    logic [2:0]    bitIdx;                           // Data bit being sent
    uartByte       shiftReg;                         // Bit 0 is the next data bit
    logic          txLine;
    logic          accept;
    logic          bitDone;

    assign accept  = txStart && (state == txIdle);   // Strobes while busy are dropped
    assign bitDone = (timer == LAST);
    assign txBusy  = (state != txIdle);
    assign Tx      = txLine;

    // **************************************************
    // Frame sequencer
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= txIdle;
            timer  <= '0;
            bitIdx <= '0;
            txLine <= 1'b1;                          // Idle high
        end else begin
            if (state == txIdle || bitDone) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end
            case (state)
                txIdle: begin
                    if (accept) begin
                        state  <= txStartBit;
                        txLine <= 1'b0;              // Start bit from the next clock
                    end
                end
                txStartBit: begin
                    if (bitDone) begin
                        state  <= uartPkg::txData;   // Enum value, port has the same name
                        txLine <= shiftReg[0];
                        bitIdx <= '0;
                    end
                end
                uartPkg::txData: begin
                    if (bitDone) begin
                        if (bitIdx == 3'd7) begin
                            state  <= txStopBit;
                            txLine <= 1'b1;
                        end else begin
                            txLine <= shiftReg[0];
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end
                end
                txStopBit: begin
                    if (bitDone) state <= txIdle;    // Busy ends with the stop bit
                end
                default: state <= txIdle;
            endcase
        end
    end

    // Byte latch and LSB-first shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= txData;
        end else if (bitDone && (state == txStartBit || state == uartPkg::txData)) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

/* tb/boardTop_checker.sv */
`timescale 1ns/1ps

module uartTxChecker #(
    parameter int CLKS_PER_BIT = 8
) (
    input logic clk,
    input logic reset,
    input logic txStart,
    input logic Tx,
    input logic txBusy
);

    int idleFails = 0;
    int startFails = 0;
    int lengthFails = 0;
    int failCount;                                   // Read by the testbench at the end
    int busyLen;                                     // Clocks with txBusy high so far

    assign failCount = idleFails + startFails + lengthFails;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busyLen <= 0;
        end else if (txBusy) begin
            busyLen <= busyLen + 1;
        end else begin
            busyLen <= 0;                            // Restart for the next frame
        end
    end

    // **************************************************
    // Frame rules
    // **************************************************
    idleHigh: assert property (@(posedge clk) disable iff (reset) !txBusy |-> Tx)
        else begin idleFails++; $error("Tx low while the transmitter is idle"); end

    // A fall from idle needs an accepted start one clock earlier
    startFall: assert property (@(posedge clk) disable iff (reset)
            ($fell(Tx) && !$past(txBusy)) |-> $past(txStart))
        else begin startFails++; $error("Tx fell without an accepted start"); end

    frameLength: assert property (@(posedge clk) disable iff (reset)
            $fell(txBusy) |-> (busyLen == 10 * CLKS_PER_BIT))   // Start, 8 data, stop
        else begin lengthFails++; $error("txBusy length is not ten bit times"); end

endmodule

bind uartTx uartTxChecker #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uartTxChecker (
    .clk(clk), .reset(reset), .txStart(txStart), .Tx(Tx), .txBusy(txBusy)
);

/* tb/boardTop_tb.sv */
`timescale 1ns/1ps

module boardTop_tb;
    import boardPkg::*;
    import uartPkg::*;

    localparam int TICK_DIV     = 4;
    localparam int CLKS_PER_BIT = 8;
    localparam int RESET_CYCLES = 4;
    localparam int HOLD_CLKS    = 3 * TICK_DIV;                // Three ticks per key phase
    localparam int START_LIMIT  = 3 * HOLD_CLKS;               // Press to start bit, with margin
    localparam int IDLE_LIMIT   = 12 * CLKS_PER_BIT;           // Longer than one frame

    logic    clk;
    logic    reset;
    pbVec    pb;
    logic    Rx;
    logic    Tx;
    segVec   ss [numDigits];                                   // ss[n] is board digit n
    ledVec   left;
    ledVec   right;
    logic    red;
    logic    green;
    logic    blue;

    integer  seed;
    int      errors;
    int      checks;
    digitReg expReg;                                           // Model of the display register
    hexDigit k;
    hexDigit k2;
    uartByte got;
    uartByte rxByte;
    uartByte expRight;
    ledVec   expLeft;

    boardTop #(
        .TICK_DIV(TICK_DIV), .CLKS_PER_BIT(CLKS_PER_BIT), .RESET_CYCLES(RESET_CYCLES)
    ) i_boardTop (
        .clk(clk), .reset(reset), .pb(pb), .Rx(Rx), .Tx(Tx),
        .ss7(ss[7]), .ss6(ss[6]), .ss5(ss[5]), .ss4(ss[4]),
        .ss3(ss[3]), .ss2(ss[2]), .ss1(ss[1]), .ss0(ss[0]),
        .left(left), .right(right), .red(red), .green(green), .blue(blue)
    );

    always #5 clk = ~clk;                                      // 10 ns period

    // **************************************************
    // Reference model
    // **************************************************
    function automatic segVec segRef(hexDigit d);
        case (d)                                               // Segments gfedcba
            4'h0: return 8'b0011_1111;
            4'h1: return 8'b0000_0110;
            4'h2: return 8'b0101_1011;
            4'h3: return 8'b0100_1111;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b0110_1101;
            4'h6: return 8'b0111_1101;
            4'h7: return 8'b0000_0111;
            4'h8: return 8'b0111_1111;
            4'h9: return 8'b0110_1111;
            4'hA: return 8'b0111_0111;
            4'hB: return 8'b0111_1100;                         // Lower-case b
            4'hC: return 8'b0011_1001;
            4'hD: return 8'b0101_1110;                         // Lower-case d
            4'hE: return 8'b0111_1001;
            default: return 8'b0111_0001;                      // F
        endcase
    endfunction

    function automatic uartByte asciiRef(hexDigit d);
        if (d <= 4'd9) return 8'h30 + {4'h0, d};               // '0'..'9'
        return 8'h37 + {4'h0, d};                              // 'A' is 0x41 for d = 10
    endfunction

    function automatic digitReg shiftRef(digitReg r, hexDigit d);
        return {r[27:0], d};                                   // Newest digit on the right
    endfunction

    function automatic pbVec keyMask(int n);
        return pbVec'(1) << n;
    endfunction

    task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s is %02h, expected %02h", $time, what, actual, expected);
        end
    endtask

    task automatic checkDisplay(input string when);
        @(negedge clk);                                        // Outputs settled
        for (int n = 0; n < numDigits; n++) begin
            checkValue(ss[n], segRef(expReg[n*4 +: 4]), $sformatf("%s ss%0d", when, n));
        end
    endtask

    task automatic checkResetState(input string when);
        expReg = '0;                                           // Every digit shows 0
        checkDisplay(when);
        checkValue(8'(Tx), 8'h01, {when, " Tx"});
        checkValue(left, 8'h00, {when, " left"});
        checkValue(right, 8'h00, {when, " right"});
        checkValue(8'(red), 8'h00, {when, " red"});
        checkValue(8'(green), 8'h00, {when, " green"});
        checkValue(8'(blue), 8'h00, {when, " blue"});
    endtask

    // **************************************************
    // Stimulus and serial models
    // **************************************************
    task automatic pressKeys(input pbVec keys, input int holdTicks);
        @(posedge clk);
        #1 pb = keys;
        repeat (holdTicks * TICK_DIV) @(posedge clk);
        #1 pb = '0;
        repeat (HOLD_CLKS) @(posedge clk);                     // Released for three ticks
    endtask

    task automatic waitTxIdle();
        int waited;
        waited = 0;
        while (red !== 1'b0 && waited < IDLE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (red !== 1'b0) begin
            errors++;
            $display("Timeout: transmitter still busy at %0d ns", $time);
        end
    endtask

    // Decodes one Tx frame at mid-bit
    task automatic readFrame(output uartByte data);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge clk);
        while (Tx !== 1'b0 && waited < START_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (Tx !== 1'b0) begin
            errors++;
            $display("Timeout: no start bit seen on Tx at %0d ns", $time);
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);          // Middle of start bit
            checkValue(8'(Tx), 8'h00, "Tx start bit");
            checkValue(8'(red), 8'h01, "red in frame");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = Tx;                                  // LSB first
                checkValue(8'(red), 8'h01, "red in frame");
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            checkValue(8'(Tx), 8'h01, "Tx stop bit");
            waitTxIdle();
        end
    endtask

    task automatic sendFrame(input uartByte data, input logic lowStop);
        @(posedge clk);
        #1 Rx = 1'b0;                                          // Start bit
        repeat (CLKS_PER_BIT) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            #1 Rx = data[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        #1 Rx = !lowStop;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1 Rx = 1'b1;                                          // Back to idle
    endtask

    // Waits for right and blue to reach the expected state
    task automatic checkReceive(input uartByte expByte, input logic expBlue);
        int waited;
        waited = 0;
        while ((right !== expByte || blue !== expBlue) && waited < 3 * CLKS_PER_BIT) begin
            @(negedge clk);
            waited++;
        end
        if (right !== expByte || blue !== expBlue) begin
            errors++;
            $display("Timeout: receive result not seen at %0d ns", $time);
        end
        checkValue(right, expByte, "right");
        checkValue(8'(green), 8'h01, "green");
        checkValue(8'(blue), 8'(expBlue), "blue");
        repeat (2 * CLKS_PER_BIT) @(posedge clk);              // Idle gap between frames
    endtask

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin
        seed   = 32'ha383_3d23;
        errors = 0;
        checks = 0;
        clk    = 1'b0;
        reset  = 1'b1;
        pb     = '0;
        Rx     = 1'b1;
        expReg = '0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        repeat (RESET_CYCLES + 2) @(posedge clk);
        checkResetState("power-on");

        // Display entry, eight random keys
        for (int i = 0; i < 8; i++) begin
            k = hexDigit'($random(seed));
            pressKeys(keyMask(k), 3);
            expReg = shiftRef(expReg, k);
        end
        checkDisplay("random entry");
        checkValue(left, asciiRef(k), "left after entry");
        k = hexDigit'($random(seed));
        pressKeys(keyMask(k), 6);                              // Held key enters once
        expReg = shiftRef(expReg, k);
        checkDisplay("held key");
        k  = hexDigit'($random(seed));
        k2 = hexDigit'($random(seed));
        if (k2 == k) k2 = k + 4'd1;                            // Two different keys
        pressKeys(keyMask(k) | keyMask(k2), 3);
        expReg  = shiftRef(expReg, (k < k2) ? k : k2);         // Lower index wins
        expLeft = asciiRef((k < k2) ? k : k2);
        checkDisplay("two keys");
        checkValue(left, expLeft, "left after two keys");
        waitTxIdle();

        // Clear key
        pressKeys(keyMask(keyClear), 3);
        expReg = '0;
        checkDisplay("clear");
        checkValue(left, expLeft, "left after clear");

        // Transmit, one frame per key
        for (int i = 0; i < 4; i++) begin
            k = hexDigit'($random(seed));
            fork
                pressKeys(keyMask(k), 3);
                readFrame(got);
            join
            expReg = shiftRef(expReg, k);
            checkValue(got, asciiRef(k), "Tx byte");
            checkValue(left, asciiRef(k), "left after send");
        end
        checkDisplay("transmit");

        // Receive, good frames then one with a low stop bit
        for (int i = 0; i < 4; i++) begin
            rxByte = uartByte'($random(seed));
            sendFrame(rxByte, 1'b0);
            checkReceive(rxByte, 1'b0);
        end
        expRight = rxByte;                                     // Last good byte
        sendFrame(uartByte'($random(seed)), 1'b1);
        checkReceive(expRight, 1'b1);                          // right kept, blue set
        rxByte = uartByte'($random(seed));
        sendFrame(rxByte, 1'b0);
        checkReceive(rxByte, 1'b1);                            // blue is sticky

        // Button reset combination
        waitTxIdle();
        pressKeys(keyMask(resetKeyA) | keyMask(resetKeyB) | keyMask(resetKeyC), 1);
        repeat (RESET_CYCLES + 2) @(posedge clk);
        checkResetState("button reset");

        errors += i_boardTop.i_uartTx.i_uartTxChecker.failCount;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
